// ==== design/ob_pkg.sv ====
`default_nettype none

package ob_pkg;

  // Number of resting orders held in the table
  localparam int TABLE_N = 16;

  // Four packed BCD digits
  // Unsigned compare of the raw bits follows numeric order
  typedef logic [15:0] price_t;

  // Quantity of a single order
  typedef logic [9:0] quantity_t;

  // Running total over the table
  // 14 bits hold TABLE_N orders of the largest quantity (16 x 1023)
  typedef logic [13:0] accum_quantity_t;

endpackage

`default_nettype wire

// ==== design/cnt_pkg.sv ====
`default_nettype none

package cnt_pkg;

  import ob_pkg::*;

  // Inputs into the carry-save tree
  localparam int CSA_DEGREE_N = 8;

  // Two tree inputs are taken by the sum and carry accumulators
  localparam int LANE_N = CSA_DEGREE_N - 2;

  // Rounds needed to cover every table entry
  localparam int ROUND_N = (TABLE_N + LANE_N - 1) / LANE_N;

  // Control states of the counter
  typedef enum logic [1:0] {
    IDLE,
    ACCUM,
    WAIT0,
    WAIT1
  } fsm_state_t;

endpackage

`default_nettype wire

// ==== design/ob_count_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module ob_count_fsm import ob_pkg::*; import cnt_pkg::*; (
  input  wire logic            clk,
  input  wire logic            reset,
  input  wire logic            cmd_vld,
  input  wire price_t          cmd_price,
  input  wire quantity_t       cmd_quantity,
  input  wire logic            round_first,
  input  wire logic            round_last,
  output logic                 busy,
  output logic                 rsp_vld,
  output logic                 round_start,
  output logic                 round_step,
  output logic                 lane_load,
  output logic                 acc_init,
  output logic                 acc_upt,
  output price_t               ctx_price,
  output accum_quantity_t      ctx_quantity
);

  fsm_state_t state;
  fsm_state_t state_nxt;
  // Command captured, scan starts next cycle
  logic       cmd_pend;
  logic       accept;

  // Only a fresh command in IDLE is taken
  assign accept = cmd_vld && (state == IDLE) && !cmd_pend;

  always_comb begin
    state_nxt   = state;
    round_start = 1'b0;
    round_step  = 1'b0;
    lane_load   = 1'b0;
    acc_init    = 1'b0;
    acc_upt     = 1'b0;
    case (state)
      IDLE: begin
        // Clear totals and point at round 0
        if (cmd_pend) begin
          acc_init    = 1'b1;
          round_start = 1'b1;
          state_nxt   = ACCUM;
        end
      end
      ACCUM: begin
        lane_load  = 1'b1;
        round_step = 1'b1;
        // Lane register not yet loaded in the first round
        acc_upt    = !round_first;
        if (round_last) begin
          state_nxt = WAIT0;
        end
      end
      WAIT0: begin
        // Fold in the last round
        acc_upt   = 1'b1;
        state_nxt = WAIT1;
      end
      WAIT1: begin
        state_nxt = IDLE;
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= IDLE;
      cmd_pend <= 1'b0;
      busy     <= 1'b0;
      rsp_vld  <= 1'b0;
    end else begin
      state    <= state_nxt;
      cmd_pend <= accept;
      // Flops track the next state so they match the state register
      busy     <= (state_nxt != IDLE);
      rsp_vld  <= (state_nxt == WAIT1);
    end
  end

  // Command context, held for the whole scan
  always_ff @(posedge clk) begin
    if (accept) begin
      ctx_price    <= cmd_price;
      ctx_quantity <= accum_quantity_t'(cmd_quantity);
    end
  end

endmodule

`default_nettype wire

// ==== design/ob_round_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module ob_round_counter import cnt_pkg::*; (
  input  wire logic         clk,
  input  wire logic         reset,
  input  wire logic         round_start,
  input  wire logic         round_step,
  output logic [ROUND_N-1:0] round_sel,
  output logic              round_first,
  output logic              round_last
);

  // One-hot pointer, bit r selects round r
  always_ff @(posedge clk) begin
    if (reset) begin
      round_sel <= '0;
    end else if (round_start) begin
      round_sel <= ROUND_N'(1);
    end else if (round_step) begin
      // Last bit shifts out, pointer goes empty
      round_sel <= round_sel << 1;
    end
  end

  assign round_first = round_sel[0];
  assign round_last  = round_sel[ROUND_N-1];

endmodule

`default_nettype wire

// ==== design/ob_lane_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module ob_lane_select import ob_pkg::*; import cnt_pkg::*; (
  input  wire logic                       clk,
  input  wire price_t    [TABLE_N-1:0]    tbl_price,
  input  wire quantity_t [TABLE_N-1:0]    tbl_quantity,
  input  wire logic      [TABLE_N-1:0]    tbl_vld,
  input  wire price_t                     ctx_price,
  input  wire logic      [ROUND_N-1:0]    round_sel,
  input  wire logic                       lane_load,
  output quantity_t      [LANE_N-1:0]     lane_quantity
);

  quantity_t [LANE_N-1:0] lane_next;

  for (genvar l = 0; l < LANE_N; l++) begin : g_lane
    // Candidate of this lane in every round
    quantity_t [ROUND_N-1:0] cand;
    quantity_t               lane_mux;

    for (genvar r = 0; r < ROUND_N; r++) begin : g_round
      // Entries are dealt from the top of the table down
      localparam int SLOT = r * LANE_N + l;
      if (SLOT < TABLE_N) begin : g_entry
        localparam int IDX = TABLE_N - 1 - SLOT;
        // Ask side, command price at or above the resting price
        assign cand[r] = (tbl_vld[IDX] && (ctx_price >= tbl_price[IDX])) ?
                         tbl_quantity[IDX] : '0;
      end else begin : g_pad
        // Past the table end
        assign cand[r] = '0;
      end
    end

    // AND-OR mux on the one-hot round pointer
    always_comb begin
      lane_mux = '0;
      for (int r = 0; r < ROUND_N; r++) begin
        if (round_sel[r]) begin
          lane_mux = lane_mux | cand[r];
        end
      end
    end

    assign lane_next[l] = lane_mux;
  end

  // Lane register feeding the carry-save tree
  always_ff @(posedge clk) begin
    if (lane_load) begin
      lane_quantity <= lane_next;
    end
  end

endmodule

`default_nettype wire

// ==== design/ob_csa_accum.sv ====
`timescale 1ns/1ps
`default_nettype none

module ob_csa_accum import ob_pkg::*; import cnt_pkg::*; (
  input  wire logic                    clk,
  input  wire logic                    reset,
  input  wire quantity_t [LANE_N-1:0]  lane_quantity,
  input  wire logic                    acc_init,
  input  wire logic                    acc_upt,
  input  wire accum_quantity_t         ctx_quantity,
  output accum_quantity_t              rsp_quantity,
  output logic                         rsp_attained
);

  accum_quantity_t [CSA_DEGREE_N-1:0] csa_x;
  accum_quantity_t                    csa_s;
  accum_quantity_t                    csa_c;
  accum_quantity_t                    acc_s;
  accum_quantity_t                    acc_c;

  // 3:2 compressor, carry weighted one bit up
  function automatic void csa32(input accum_quantity_t a, input accum_quantity_t b,
                                input accum_quantity_t c, output accum_quantity_t s,
                                output accum_quantity_t co);
    s  = a ^ b ^ c;
    co = ((a & b) | (a & c) | (b & c)) << 1;
  endfunction

  // Lanes first, then the running sum and carry
  always_comb begin
    for (int i = 0; i < LANE_N; i++) begin
      csa_x[i] = accum_quantity_t'(lane_quantity[i]);
    end
    csa_x[CSA_DEGREE_N-2] = acc_s;
    csa_x[CSA_DEGREE_N-1] = acc_c;
  end

  // Eight inputs down to two in four levels
  always_comb begin
    accum_quantity_t [5:0] s;
    accum_quantity_t [5:0] c;
    // Level 1, 8 -> 6
    csa32(csa_x[0], csa_x[1], csa_x[2], s[0], c[0]);
    csa32(csa_x[3], csa_x[4], csa_x[5], s[1], c[1]);
    // Level 2, 6 -> 4
    csa32(s[0], c[0], s[1], s[2], c[2]);
    csa32(c[1], csa_x[6], csa_x[7], s[3], c[3]);
    // Level 3, 4 -> 3
    csa32(s[2], c[2], s[3], s[4], c[4]);
    // Level 4, 3 -> 2
    csa32(s[4], c[4], c[3], s[5], c[5]);
    csa_s = s[5];
    csa_c = c[5];
  end

  always_ff @(posedge clk) begin
    if (reset || acc_init) begin
      acc_s <= '0;
      acc_c <= '0;
    end else if (acc_upt) begin
      acc_s <= csa_s;
      acc_c <= csa_c;
    end
  end

  // Single carry-propagate add at the end
  assign rsp_quantity = acc_s + acc_c;
  assign rsp_attained = (rsp_quantity >= ctx_quantity);

endmodule

`default_nettype wire

// ==== design/ob_table_count.sv ====
`timescale 1ns/1ps
`default_nettype none

module ob_table_count import ob_pkg::*; import cnt_pkg::*; (
  input  wire logic                      clk,
  input  wire logic                      reset,
  input  wire logic                      cmd_vld,
  input  wire price_t                    cmd_price,
  input  wire quantity_t                 cmd_quantity,
  input  wire price_t    [TABLE_N-1:0]   tbl_price,
  input  wire quantity_t [TABLE_N-1:0]   tbl_quantity,
  input  wire logic      [TABLE_N-1:0]   tbl_vld,
  output logic                           busy,
  output logic                           rsp_vld,
  output accum_quantity_t                rsp_quantity,
  output logic                           rsp_attained
);

  // FSM to round counter
  logic                   round_start;
  logic                   round_step;
  logic                   round_first;
  logic                   round_last;
  logic [ROUND_N-1:0]     round_sel;

  // FSM to datapath
  logic                   lane_load;
  logic                   acc_init;
  logic                   acc_upt;
  price_t                 ctx_price;
  accum_quantity_t        ctx_quantity;

  quantity_t [LANE_N-1:0] lane_quantity;

  ob_count_fsm u_fsm (
    .clk          (clk),
    .reset        (reset),
    .cmd_vld      (cmd_vld),
    .cmd_price    (cmd_price),
    .cmd_quantity (cmd_quantity),
    .round_first  (round_first),
    .round_last   (round_last),
    .busy         (busy),
    .rsp_vld      (rsp_vld),
    .round_start  (round_start),
    .round_step   (round_step),
    .lane_load    (lane_load),
    .acc_init     (acc_init),
    .acc_upt      (acc_upt),
    .ctx_price    (ctx_price),
    .ctx_quantity (ctx_quantity)
  );

  ob_round_counter u_round (
    .clk         (clk),
    .reset       (reset),
    .round_start (round_start),
    .round_step  (round_step),
    .round_sel   (round_sel),
    .round_first (round_first),
    .round_last  (round_last)
  );

  ob_lane_select u_lanes (
    .clk           (clk),
    .tbl_price     (tbl_price),
    .tbl_quantity  (tbl_quantity),
    .tbl_vld       (tbl_vld),
    .ctx_price     (ctx_price),
    .round_sel     (round_sel),
    .lane_load     (lane_load),
    .lane_quantity (lane_quantity)
  );

  ob_csa_accum u_accum (
    .clk           (clk),
    .reset         (reset),
    .lane_quantity (lane_quantity),
    .acc_init      (acc_init),
    .acc_upt       (acc_upt),
    .ctx_quantity  (ctx_quantity),
    .rsp_quantity  (rsp_quantity),
    .rsp_attained  (rsp_attained)
  );

endmodule

`default_nettype wire

// ==== testbench/ob_table_count_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module ob_table_count_props (
  input wire logic clk,
  input wire logic reset,
  input wire logic cmd_vld,
  input wire logic busy,
  input wire logic rsp_vld
);

  // Response strobe is a single cycle
  a_rsp_single: assert property (@(posedge clk) disable iff (reset) rsp_vld |=> !rsp_vld)
    else $error("rsp_vld held high for two cycles");

  // Response only while the counter is busy
  a_rsp_busy: assert property (@(posedge clk) disable iff (reset) rsp_vld |-> busy)
    else $error("rsp_vld high while busy is low");

  // Counter goes idle right after the response
  a_busy_fall: assert property (@(posedge clk) disable iff (reset) rsp_vld |=> !busy)
    else $error("busy still high after rsp_vld");

  // busy is registered behind the command capture, so it shows two samples later
  a_busy_rise: assert property (@(posedge clk) disable iff (reset) (cmd_vld && !busy) |-> ##2 busy)
    else $error("busy did not rise after a command in idle");

endmodule

`default_nettype wire

// ==== testbench/tb_ob_table_count.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ob_table_count import ob_pkg::*; ();

  localparam int SEED           = 60;
  localparam int CMD_N          = 200;
  localparam int LATENCY        = 5;
  localparam int TIMEOUT_CYCLES = CMD_N * 10;
  localparam int DRIVE_DELAY    = 1;

  logic                        clk;
  logic                        reset;
  logic                        cmd_vld;
  price_t                      cmd_price;
  quantity_t                   cmd_quantity;
  price_t    [TABLE_N-1:0]     tbl_price;
  quantity_t [TABLE_N-1:0]     tbl_quantity;
  logic      [TABLE_N-1:0]     tbl_vld;
  logic                        busy;
  logic                        rsp_vld;
  accum_quantity_t             rsp_quantity;
  logic                        rsp_attained;

  // Decimal view of the table prices for the model
  int          price_dec [TABLE_N];
  int          cmd_dec;
  logic [31:0] rng_state;
  int          cycle_count;
  int          hit_count;
  int          miss_count;

  ob_table_count dut (
    .clk          (clk),
    .reset        (reset),
    .cmd_vld      (cmd_vld),
    .cmd_price    (cmd_price),
    .cmd_quantity (cmd_quantity),
    .tbl_price    (tbl_price),
    .tbl_quantity (tbl_quantity),
    .tbl_vld      (tbl_vld),
    .busy         (busy),
    .rsp_vld      (rsp_vld),
    .rsp_quantity (rsp_quantity),
    .rsp_attained (rsp_attained)
  );

  bind ob_table_count ob_table_count_props u_props (
    .clk     (clk),
    .reset   (reset),
    .cmd_vld (cmd_vld),
    .busy    (busy),
    .rsp_vld (rsp_vld)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Run limit so a hung handshake ends the run
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: no response after %0d cycles", cycle_count);
      $display("*** FAILED ***");
      $fatal(1, "Simulation timed out");
    end
  end

  // LCG returning its upper bits
  function automatic int next_random();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return int'(rng_state >> 8);
  endfunction

  // Decimal 0 to 9999 into four BCD digits
  function automatic price_t to_bcd(input int value);
    price_t bcd;
    bcd[15:12] = 4'((value / 1000) % 10);
    bcd[11:8]  = 4'((value / 100) % 10);
    bcd[7:4]   = 4'((value / 10) % 10);
    bcd[3:0]   = 4'(value % 10);
    return bcd;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("** Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
      $display("*** FAILED ***");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // Mode 0 fills the table at random
  // Mode 1 leaves every entry invalid
  // Mode 2 makes every entry valid at full quantity and top price
  task automatic fill_table(input int mode);
    for (int i = 0; i < TABLE_N; i++) begin
      if (mode == 2) begin
        price_dec[i] = 9999;
      end else if (next_random() % 10 == 0) begin
        price_dec[i] = next_random() % 10000;
      end else begin
        // Narrow band so the price compare splits
        price_dec[i] = 1200 + next_random() % 64;
      end
      tbl_price[i] = to_bcd(price_dec[i]);
      if (mode == 2) begin
        tbl_quantity[i] = 10'd1023;
      end else if (next_random() % 8 == 0) begin
        tbl_quantity[i] = quantity_t'(next_random() % 1024);
      end else begin
        tbl_quantity[i] = quantity_t'(next_random() % 128);
      end
      tbl_vld[i] = (mode == 2) || ((mode == 0) && (next_random() % 4 != 0));
    end
  endtask

  // Ask side counts an entry when its price is at most the command price
  function automatic int model_sum();
    int sum;
    sum = 0;
    for (int i = 0; i < TABLE_N; i++) begin
      if (tbl_vld[i] && (price_dec[i] <= cmd_dec)) begin
        sum += int'(tbl_quantity[i]);
      end
    end
    return sum;
  endfunction

  // Target near the sum and sometimes exactly on it
  function automatic int pick_target(input int sum);
    int t;
    if (next_random() % 8 == 0) begin
      t = sum;
    end else begin
      t = sum + (next_random() % 129) - 64;
    end
    if (t < 0) begin
      t = 0;
    end
    if (t > 1023) begin
      t = 1023;
    end
    return t;
  endfunction

  // Entered and left a drive delay after an edge with the DUT idle
  task automatic run_command(input int idx);
    int expect_sum;
    int target;
    int cycles;
    int dup_cycle;
    bit dup;
    bit expect_hit;
    check_value("busy", busy, 0);
    if (idx == 0) begin
      fill_table(1);
      cmd_dec = 9999;
      target  = 5;
    end else if (idx == 1) begin
      fill_table(2);
      cmd_dec = 9999;
      target  = 1023;
    end else begin
      fill_table(0);
      cmd_dec = 1190 + next_random() % 84;
      target  = 0;
    end
    expect_sum = model_sum();
    if (idx >= 2) begin
      target = pick_target(expect_sum);
    end
    expect_hit = (expect_sum >= target);
    // Only random targets count toward the attained and missed tallies
    if (idx >= 2) begin
      if (expect_hit) begin
        hit_count++;
      end else begin
        miss_count++;
      end
    end
    // Every tenth command gets a stray strobe while busy
    dup       = (idx % 10 == 5);
    dup_cycle = 1 + next_random() % 4;
    cmd_price    = to_bcd(cmd_dec);
    cmd_quantity = quantity_t'(target);
    cmd_vld      = 1'b1;
    @(posedge clk);
    #DRIVE_DELAY;
    cmd_vld = 1'b0;
    check_value("busy", busy, 0);
    check_value("rsp_vld", rsp_vld, 0);
    cycles = 0;
    do begin
      @(posedge clk);
      #DRIVE_DELAY;
      cycles++;
      if (dup && (cycles == dup_cycle)) begin
        // Would change the result if it were taken
        cmd_vld      = 1'b1;
        cmd_price    = to_bcd(9999);
        cmd_quantity = '0;
      end else begin
        cmd_vld = 1'b0;
      end
      check_value("busy", busy, 1);
    end while (!rsp_vld);
    check_value("rsp_vld latency", cycles, LATENCY);
    check_value("rsp_quantity", rsp_quantity, expect_sum);
    check_value("rsp_attained", rsp_attained, expect_hit);
    @(posedge clk);
    #DRIVE_DELAY;
    check_value("rsp_vld", rsp_vld, 0);
    check_value("busy", busy, 0);
    // Result holds after the strobe
    check_value("rsp_quantity", rsp_quantity, expect_sum);
    check_value("rsp_attained", rsp_attained, expect_hit);
    if (dup) begin
      // No second response from the ignored strobe
      repeat (LATENCY + 2) begin
        @(posedge clk);
        #DRIVE_DELAY;
        check_value("rsp_vld", rsp_vld, 0);
        check_value("busy", busy, 0);
      end
    end
  endtask

  initial begin
    rng_state    = SEED;
    cycle_count  = 0;
    hit_count    = 0;
    miss_count   = 0;
    reset        = 1'b1;
    cmd_vld      = 1'b0;
    cmd_price    = '0;
    cmd_quantity = '0;
    tbl_price    = '0;
    tbl_quantity = '0;
    tbl_vld      = '0;
    repeat (2) @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;
    check_value("busy", busy, 0);
    check_value("rsp_vld", rsp_vld, 0);
    for (int i = 0; i < CMD_N; i++) begin
      run_command(i);
    end
    if ((hit_count > 0) && (miss_count > 0)) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("Random targets did not give both attained and missed outcomes");
      $display("*** FAILED ***");
      $fatal(1, "Attained flag outcomes incomplete");
    end
  end

endmodule

`default_nettype wire

// ==== project.f ====
design/ob_pkg.sv
design/cnt_pkg.sv
design/ob_count_fsm.sv
design/ob_round_counter.sv
design/ob_lane_select.sv
design/ob_csa_accum.sv
design/ob_table_count.sv
testbench/ob_table_count_props.sv
testbench/tb_ob_table_count.sv
